// ==== hdl/byte_bridge_cfg.svh ====
/* Word width, bytes per word and receive idle timeout macros */
`ifndef BYTE_BRIDGE_CFG_SVH
`define BYTE_BRIDGE_CFG_SVH

// Register side word width in bits
`define BB_WORD_WIDTH 32

// Channel bytes that make up one word
`define BB_WORD_BYTES (`BB_WORD_WIDTH / 8)

// Idle cycles after the last received byte before a partial word is flushed
`define BB_IDLE_CYCLES 8

`endif

// ==== hdl/byte_bridge_pkg.sv ====
/* Shared vector typedefs, receive framing state enum and idle timer control struct */
`default_nettype none

`include "byte_bridge_cfg.svh"

package byte_bridge_pkg;

  // Data widths
  typedef logic [`BB_WORD_WIDTH-1:0] word_t;
  typedef logic [7:0] byte_t;

  // Byte count, 0 up to a full word inclusive
  typedef logic [$clog2(`BB_WORD_BYTES):0] byte_cnt_t;

  // Idle cycle count, saturates at the timeout
  typedef logic [$clog2(`BB_IDLE_CYCLES):0] idle_cnt_t;

  // Receive framing
  typedef enum logic [1:0] {
    EMPTY = 2'd0,
    FILL  = 2'd1,
    DRAIN = 2'd2
  } rx_state_e;

  // Idle timer control, clear wins over run
  typedef struct packed {
    logic clear;
    logic run;
  } timer_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/word_serializer.sv ====
/* Word to byte converter, sends the most significant byte first */
`default_nettype none
`timescale 1ns/1ps

`include "byte_bridge_cfg.svh"

module word_serializer (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  byte_bridge_pkg::word_t in_data_i,

  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output byte_bridge_pkg::byte_t out_data_o
);

  import byte_bridge_pkg::*;

  localparam byte_cnt_t full_cnt = byte_cnt_t'(`BB_WORD_BYTES);

  // Bytes still to send
  byte_cnt_t bcnt;
  word_t     sreg;
  logic      load;
  logic      shift;

  assign load  = in_valid_i && in_ready_o;
  assign shift = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      bcnt <= '0;
    end else if (load) begin
      bcnt <= full_cnt;
    end else if (shift) begin
      bcnt <= bcnt - byte_cnt_t'(1);
    end
  end

  // Next byte always sits at the top of the shift register
  always_ff @(posedge clk_i) begin
    if (load) begin
      sreg <= in_data_i;
    end else if (shift) begin
      sreg <= sreg << 8;
    end
  end

  assign in_ready_o  = (bcnt == '0);
  assign out_valid_o = (bcnt != '0);
  assign out_data_o  = sreg[`BB_WORD_WIDTH-1 -: 8];

endmodule

`default_nettype wire

// ==== hdl/byte_assembler.sv ====
/* Byte to word converter, fills the least significant byte first, with flush of a
   partial word */
`default_nettype none
`timescale 1ns/1ps

`include "byte_bridge_cfg.svh"

module byte_assembler (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  byte_bridge_pkg::byte_t in_data_i,
  input  logic                   in_flush_i,

  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output byte_bridge_pkg::word_t out_data_o
);

  import byte_bridge_pkg::*;

  localparam byte_cnt_t full_cnt = byte_cnt_t'(`BB_WORD_BYTES);

  // Bytes stored so far, full count marks a valid word
  byte_cnt_t bcnt;
  word_t     sreg;
  logic      take_byte;
  logic      take_word;

  assign take_byte = in_valid_i && in_ready_o;
  assign take_word = out_valid_o && out_ready_i;

  // Flush closes the word early
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      bcnt <= '0;
    end else if (in_flush_i) begin
      bcnt <= full_cnt;
    end else if (take_byte) begin
      bcnt <= bcnt + byte_cnt_t'(1);
    end else if (take_word) begin
      bcnt <= '0;
    end
  end

  // A byte taken on the flush edge still lands in its slot
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sreg <= '0;
    end else if (take_byte) begin
      sreg[bcnt*8 +: 8] <= in_data_i;
    end else if (take_word) begin
      // Unfilled slots of the next short word read as zero
      sreg <= '0;
    end
  end

  assign in_ready_o  = (bcnt != full_cnt);
  assign out_valid_o = (bcnt == full_cnt);
  assign out_data_o  = sreg;

endmodule

`default_nettype wire

// ==== hdl/idle_timer.sv ====
/* Saturating idle cycle counter with a registered expiry level */
`default_nettype none
`timescale 1ns/1ps

`include "byte_bridge_cfg.svh"

module idle_timer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  byte_bridge_pkg::timer_ctrl_t ctrl_i,
  output logic                        expired_o
);

  import byte_bridge_pkg::*;

  localparam idle_cnt_t idle_max = idle_cnt_t'(`BB_IDLE_CYCLES);

  idle_cnt_t cnt;
  idle_cnt_t cnt_next;

  // Stops at the timeout value
  always_comb begin
    cnt_next = cnt;
    if (ctrl_i.clear) begin
      cnt_next = '0;
    end else if (ctrl_i.run && (cnt != idle_max)) begin
      cnt_next = cnt + idle_cnt_t'(1);
    end
  end

  // Expiry tracks the count register without extra lag
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt       <= '0;
      expired_o <= 1'b0;
    end else begin
      cnt       <= cnt_next;
      expired_o <= (cnt_next == idle_max);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rx_flush_fsm.sv ====
/* Receive framing FSM, drives the idle timer and flushes a partial word after an
   idle gap */
`default_nettype none
`timescale 1ns/1ps

module rx_flush_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        byte_take_i,
  input  logic                        word_take_i,
  input  logic                        word_full_i,
  input  logic                        expired_i,
  output byte_bridge_pkg::timer_ctrl_t timer_o,
  output logic                        flush_o
);

  import byte_bridge_pkg::*;

  rx_state_e state;
  rx_state_e state_d;
  logic      flush_d;

  // Timer only runs while a partial word waits for more bytes
  assign timer_o.clear = (state != FILL) || byte_take_i;
  assign timer_o.run   = (state == FILL) && !byte_take_i;

  always_comb begin
    state_d = state;
    flush_d = 1'b0;
    case (state)
      EMPTY: begin
        if (byte_take_i) begin
          state_d = FILL;
        end
      end
      FILL: begin
        if (flush_o) begin
          // Word becomes valid on this edge
          state_d = DRAIN;
        end else if (word_full_i) begin
          // Completed by its last byte, may leave in the same cycle
          state_d = word_take_i ? EMPTY : DRAIN;
        end else if (expired_i && !byte_take_i) begin
          flush_d = 1'b1;
        end
      end
      DRAIN: begin
        if (word_take_i) begin
          state_d = byte_take_i ? FILL : EMPTY;
        end
      end
      default: begin
        state_d = EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state   <= EMPTY;
      flush_o <= 1'b0;
    end else begin
      state   <= state_d;
      flush_o <= flush_d;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/byte_bridge.sv ====
/* Top level, transmit word serializer and receive byte assembler with idle gap flush */
`default_nettype none
`timescale 1ns/1ps

module byte_bridge (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Transmit words in
  input  logic                   tx_word_valid_i,
  output logic                   tx_word_ready_o,
  input  byte_bridge_pkg::word_t tx_word_i,

  // Transmit bytes out
  output logic                   tx_byte_valid_o,
  input  logic                   tx_byte_ready_i,
  output byte_bridge_pkg::byte_t tx_byte_o,

  // Receive bytes in
  input  logic                   rx_byte_valid_i,
  output logic                   rx_byte_ready_o,
  input  byte_bridge_pkg::byte_t rx_byte_i,

  // Receive words out
  output logic                   rx_word_valid_o,
  input  logic                   rx_word_ready_i,
  output byte_bridge_pkg::word_t rx_word_o
);

  import byte_bridge_pkg::*;

  logic        byte_take;
  logic        word_take;
  logic        flush;
  logic        expired;
  timer_ctrl_t timer_ctrl;

  // Transmit path, counter only
  word_serializer word_serializer_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (tx_word_valid_i),
    .in_ready_o  (tx_word_ready_o),
    .in_data_i   (tx_word_i),
    .out_valid_o (tx_byte_valid_o),
    .out_ready_i (tx_byte_ready_i),
    .out_data_o  (tx_byte_o)
  );

  // Receive path
  byte_assembler byte_assembler_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (rx_byte_valid_i),
    .in_ready_o  (rx_byte_ready_o),
    .in_data_i   (rx_byte_i),
    .in_flush_i  (flush),
    .out_valid_o (rx_word_valid_o),
    .out_ready_i (rx_word_ready_i),
    .out_data_o  (rx_word_o)
  );

  // Transfer strobes for the framing FSM
  assign byte_take = rx_byte_valid_i && rx_byte_ready_o;
  assign word_take = rx_word_valid_o && rx_word_ready_i;

  rx_flush_fsm rx_flush_fsm_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .byte_take_i (byte_take),
    .word_take_i (word_take),
    .word_full_i (rx_word_valid_o),
    .expired_i   (expired),
    .timer_o     (timer_ctrl),
    .flush_o     (flush)
  );

  idle_timer idle_timer_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .ctrl_i    (timer_ctrl),
    .expired_o (expired)
  );

endmodule

`default_nettype wire

// ==== tests/byte_bridge_checker.sv ====
/* Bound assertions on byte_bridge handshake stability, flush framing and transmit
   ready/valid exclusion */
`default_nettype none
`timescale 1ns/1ps

module byte_bridge_checker (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      tx_word_ready_i,
  input logic                      tx_byte_valid_i,
  input logic                      tx_byte_ready_i,
  input byte_bridge_pkg::byte_t    tx_byte_i,
  input logic                      rx_word_valid_i,
  input logic                      rx_word_ready_i,
  input byte_bridge_pkg::word_t    rx_word_i,
  input logic                      flush_i,
  input byte_bridge_pkg::rx_state_e rx_state_i
);

  import byte_bridge_pkg::*;

  // Failed assertions so far, polled by the testbench
  int unsigned err_count = 0;

  tx_byte_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_byte_valid_i && !tx_byte_ready_i |=> tx_byte_valid_i && $stable(tx_byte_i))
    else begin
      $error("tx byte dropped or changed while stalled");
      err_count++;
    end

  rx_word_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_word_valid_i && !rx_word_ready_i |=> rx_word_valid_i && $stable(rx_word_i))
    else begin
      $error("rx word dropped or changed while stalled");
      err_count++;
    end

  // Flush pulse only while a partial word is open
  flush_in_fill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |-> rx_state_i == FILL)
    else begin
      $error("flush outside FILL");
      err_count++;
    end

  tx_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(tx_word_ready_i && tx_byte_valid_i))
    else begin
      $error("tx word ready while bytes still pending");
      err_count++;
    end

endmodule

bind byte_bridge byte_bridge_checker byte_bridge_checker_i (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .tx_word_ready_i (tx_word_ready_o),
  .tx_byte_valid_i (tx_byte_valid_o),
  .tx_byte_ready_i (tx_byte_ready_i),
  .tx_byte_i       (tx_byte_o),
  .rx_word_valid_i (rx_word_valid_o),
  .rx_word_ready_i (rx_word_ready_i),
  .rx_word_i       (rx_word_o),
  .flush_i         (flush),
  .rx_state_i      (rx_flush_fsm_i.state)
);

`default_nettype wire

// ==== tests/byte_bridge_tb.sv ====
/* Testbench for byte_bridge, random traffic on both paths against a transmit byte
   queue and a receive word model, with a watchdog */
`default_nettype none
`timescale 1ns/1ps

`include "byte_bridge_cfg.svh"

module byte_bridge_tb;

  import byte_bridge_pkg::*;

  localparam int clk_period = 20;
  localparam int n_tx_words = 60;
  localparam int n_bursts   = 40;
  localparam int max_burst  = 6;
  localparam int max_gap    = `BB_IDLE_CYCLES + 8;
  // Timer clears on the byte edge and counts to the limit, then one edge
  // registers the flush pulse and one more closes the word
  localparam int flush_lag  = `BB_IDLE_CYCLES + 2;
  // Four times the unstalled length of both streams
  localparam int wd_cycles  = 4 * (n_tx_words * (`BB_WORD_BYTES + 3)
                              + n_bursts * (max_burst * 3 + max_gap + flush_lag)) + 100;

  logic  clk_i = 1'b0;
  logic  rst_ni;
  logic  tx_word_valid_i;
  logic  tx_word_ready_o;
  word_t tx_word_i;
  logic  tx_byte_valid_o;
  logic  tx_byte_ready_i;
  byte_t tx_byte_o;
  logic  rx_byte_valid_i;
  logic  rx_byte_ready_o;
  byte_t rx_byte_i;
  logic  rx_word_valid_o;
  logic  rx_word_ready_i;
  word_t rx_word_o;

  integer seed = 32'hb69a;
  logic   monitor_en = 1'b0;

  // Expected transmit bytes and the receive word being built
  byte_t tx_q[$];
  word_t m_word = '0;
  int    m_cnt = 0;
  int    m_idle = 0;
  logic  m_pending = 1'b0;
  int    n_flushed = 0;
  int    n_full = 0;

  always #(clk_period / 2) clk_i = ~clk_i;

  byte_bridge byte_bridge_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .tx_word_valid_i (tx_word_valid_i),
    .tx_word_ready_o (tx_word_ready_o),
    .tx_word_i       (tx_word_i),
    .tx_byte_valid_o (tx_byte_valid_o),
    .tx_byte_ready_i (tx_byte_ready_i),
    .tx_byte_o       (tx_byte_o),
    .rx_byte_valid_i (rx_byte_valid_i),
    .rx_byte_ready_o (rx_byte_ready_o),
    .rx_byte_i       (rx_byte_i),
    .rx_word_valid_o (rx_word_valid_o),
    .rx_word_ready_i (rx_word_ready_i),
    .rx_word_o       (rx_word_o)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "Run stopped after a failure");
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("[ERROR] %s: expected 0x%h, actual 0x%h", name, expected, actual));
    end
  endtask

  // Applies the transfers of the coming rising edge to the receive model
  task automatic update_rx_model();
    logic flush_now;
    flush_now = (m_cnt > 0) && !m_pending && (m_idle == flush_lag - 1);
    if (rx_word_valid_o && rx_word_ready_i) begin
      m_word    = '0;
      m_cnt     = 0;
      m_idle    = 0;
      m_pending = 1'b0;
    end
    if (rx_byte_valid_i && rx_byte_ready_o) begin
      // Least significant byte first
      m_word[m_cnt*8 +: 8] = rx_byte_i;
      m_cnt++;
      m_idle = 0;
    end else if (m_cnt > 0 && !m_pending) begin
      m_idle++;
    end
    if (!m_pending && (flush_now || m_cnt == `BB_WORD_BYTES)) begin
      m_pending = 1'b1;
      if (m_cnt == `BB_WORD_BYTES) begin
        n_full++;
      end else begin
        n_flushed++;
      end
    end
  endtask

  // Outputs are stable at the falling edge, between drive edges
  always @(negedge clk_i) begin
    if (monitor_en) begin
      check_value("tx word ready", word_t'(tx_q.size() == 0), word_t'(tx_word_ready_o));
      check_value("tx byte valid", word_t'(tx_q.size() != 0), word_t'(tx_byte_valid_o));
      if (tx_q.size() != 0) begin
        check_value("tx byte data", word_t'(tx_q[0]), word_t'(tx_byte_o));
      end
      check_value("rx word valid", word_t'(m_pending), word_t'(rx_word_valid_o));
      check_value("rx byte ready", word_t'(!m_pending), word_t'(rx_byte_ready_o));
      if (m_pending) begin
        check_value("rx word data", m_word, rx_word_o);
      end
      if (byte_bridge_i.byte_bridge_checker_i.err_count != 0) begin
        abort_run("A bound assertion on the DUT failed");
      end
      if (tx_byte_valid_o && tx_byte_ready_i) begin
        void'(tx_q.pop_front());
      end
      if (tx_word_valid_i && tx_word_ready_o) begin
        // Most significant byte goes out first
        for (int i = `BB_WORD_BYTES - 1; i >= 0; i--) begin
          tx_q.push_back(tx_word_i[i*8 +: 8]);
        end
      end
      update_rx_model();
    end
  end

  task automatic drive_ready();
    forever begin
      @(posedge clk_i);
      tx_byte_ready_i <= ($random(seed) & 3) != 0;
      rx_word_ready_i <= ($random(seed) & 3) != 0;
    end
  endtask

  task automatic send_tx_words();
    repeat (n_tx_words) begin
      tx_word_valid_i <= 1'b1;
      tx_word_i       <= word_t'($random(seed));
      @(negedge clk_i);
      while (!tx_word_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      tx_word_valid_i <= 1'b0;
      repeat ($unsigned($random(seed)) % 3) @(posedge clk_i);
    end
  endtask

  task automatic send_rx_byte(input byte_t data);
    rx_byte_valid_i <= 1'b1;
    rx_byte_i       <= data;
    @(negedge clk_i);
    while (!rx_byte_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    rx_byte_valid_i <= 1'b0;
  endtask

  task automatic send_rx_bursts();
    int len;
    int gap;
    repeat (n_bursts) begin
      len = 1 + ($unsigned($random(seed)) % max_burst);
      repeat (len) begin
        send_rx_byte(byte_t'($random(seed)));
        repeat ($unsigned($random(seed)) % 3) @(posedge clk_i);
      end
      // Gap either inside the timeout or around and past it
      if (($random(seed) & 1) != 0) begin
        gap = `BB_IDLE_CYCLES + ($unsigned($random(seed)) % 9);
      end else begin
        gap = $unsigned($random(seed)) % `BB_IDLE_CYCLES;
      end
      repeat (gap) @(posedge clk_i);
    end
  endtask

  initial begin
    #(wd_cycles * clk_period);
    abort_run($sformatf("Timeout: traffic did not finish within %0d cycles", wd_cycles));
  end

  initial begin
    rst_ni          <= 1'b0;
    tx_word_valid_i <= 1'b0;
    tx_word_i       <= '0;
    tx_byte_ready_i <= 1'b0;
    rx_byte_valid_i <= 1'b0;
    rx_byte_i       <= '0;
    rx_word_ready_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni     <= 1'b1;
    monitor_en = 1'b1;
    @(negedge clk_i);
    check_value("reset tx byte valid", '0, word_t'(tx_byte_valid_o));
    check_value("reset rx word valid", '0, word_t'(rx_word_valid_o));
    check_value("reset tx word ready", word_t'(1), word_t'(tx_word_ready_o));
    check_value("reset rx byte ready", word_t'(1), word_t'(rx_byte_ready_o));
    @(posedge clk_i);
    fork
      drive_ready();
    join_none
    fork
      send_tx_words();
      send_rx_bursts();
    join
    while (tx_q.size() != 0 || m_cnt != 0 || m_pending) @(posedge clk_i);
    if (n_flushed == 0 || n_full == 0) begin
      abort_run("Traffic never produced both a flushed and a full receive word");
    end
    if (byte_bridge_i.byte_bridge_checker_i.err_count != 0) begin
      abort_run("A bound assertion on the DUT failed");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== byte_bridge.f ====
+incdir+hdl
hdl/byte_bridge_pkg.sv
hdl/word_serializer.sv
hdl/byte_assembler.sv
hdl/idle_timer.sv
hdl/rx_flush_fsm.sv
hdl/byte_bridge.sv
tests/byte_bridge_checker.sv
tests/byte_bridge_tb.sv

// ==== Makefile ====
# Verilator flow for byte_bridge
SIM        := verilator
TOP        := byte_bridge_tb
FILELIST   := byte_bridge.f
BUILD_DIR  := obj_dir
COMMON     := --timing --assert --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary -j 0 --Mdir $(BUILD_DIR) $(COMMON)
RUN_FLAGS  := +verilator+error+limit+1000
SOURCES    := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(SIM_FLAGS)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(BUILD_DIR)
